//--- Bender.yml
package:
  name: axi_rd_slave

sources:
  - axi_rd_pkg.sv
  - rr_arbiter.sv
  - burst_addr_gen.sv
  - ost_entry.sv
  - ost_table.sv
  - r_channel_ctrl.sv
  - axi_rd_slave.sv
  - target: simulation
    files:
      - tb_axi_rd_slave.sv

//--- all.f
axi_rd_pkg.sv
rr_arbiter.sv
burst_addr_gen.sv
ost_entry.sv
ost_table.sv
r_channel_ctrl.sv
axi_rd_slave.sv
tb_axi_rd_slave.sv

//--- axi_rd_pkg.sv
/*
 * Shared field widths, vector types and codes for the AXI read slave.
 * Bursts are limited to MAX_BURST_LEN beats and arlen above 7 is not checked.
 * FETCH_BASE_DLY must stay above the largest ID so the fetch delay is never zero.
 */
package axi_rd_pkg;

    // ------------------------------
    // AXI field widths
    // ------------------------------
    localparam int ID_W   = 4;
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int LEN_W  = 8;
    localparam int SIZE_W = 3;
    localparam int RESP_W = 2;

    // Burst buffer depth per outstanding entry
    localparam int MAX_BURST_LEN = 8;
    localparam int BEAT_IDX_W    = $clog2(MAX_BURST_LEN);

    // Fetch delay per beat is this minus the transaction ID
    localparam int FETCH_BASE_DLY = 20;

    typedef logic [ID_W-1:0]       id_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [LEN_W-1:0]      len_t;
    typedef logic [SIZE_W-1:0]     size_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [RESP_W-1:0]     resp_t;
    typedef logic [BEAT_IDX_W-1:0] beat_idx_t;
    typedef logic [4:0]            fetch_cnt_t;

    // AXI burst type encoding
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    // Response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

//--- axi_rd_slave.sv
`timescale 1ns/1ps
/*
 * AXI read-only slave with a modelled slow memory and out-of-order completion.
 * Beat data is the zero-extended ID and beat address, and the last beat of ID 15
 * returns SLVERR. Bursts up to 8 beats, OST_DEPTH a power of two.
 */
module axi_rd_slave #(
    parameter int OST_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,

    // AR channel
    input  logic               arvalid,
    output logic               arready,
    input  axi_rd_pkg::id_t    arid,
    input  axi_rd_pkg::addr_t  araddr,
    input  axi_rd_pkg::len_t   arlen,
    input  axi_rd_pkg::size_t  arsize,
    input  axi_rd_pkg::burst_e arburst,

    // R channel
    output logic               rvalid,
    input  logic               rready,
    output axi_rd_pkg::id_t    rid,
    output axi_rd_pkg::data_t  rdata,
    output axi_rd_pkg::resp_t  rresp,
    output logic               rlast
);
    import axi_rd_pkg::*;

    // Per-entry beat interface
    logic [OST_DEPTH-1:0] beat_ready;
    logic [OST_DEPTH-1:0] beat_last;
    logic [OST_DEPTH-1:0] beat_sent;
    id_t                  beat_id   [OST_DEPTH];
    data_t                beat_data [OST_DEPTH];
    resp_t                beat_resp [OST_DEPTH];

    ost_table #(
        .OST_DEPTH (OST_DEPTH)
    ) u_ost_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .arvalid    (arvalid),
        .arid       (arid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .arready    (arready),
        .beat_sent  (beat_sent),
        .beat_ready (beat_ready),
        .beat_id    (beat_id),
        .beat_data  (beat_data),
        .beat_resp  (beat_resp),
        .beat_last  (beat_last)
    );

    r_channel_ctrl #(
        .OST_DEPTH (OST_DEPTH)
    ) u_r_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_ready (beat_ready),
        .beat_id    (beat_id),
        .beat_data  (beat_data),
        .beat_resp  (beat_resp),
        .beat_last  (beat_last),
        .beat_sent  (beat_sent),
        .rvalid     (rvalid),
        .rready     (rready),
        .rid        (rid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast)
    );

endmodule

//--- burst_addr_gen.sv
`timescale 1ns/1ps
/*
 * Next beat address for FIXED, INCR and WRAP bursts.
 * WRAP assumes a legal length of 2, 4, 8 or 16 beats so the span is a power of two.
 * INCR does not stop at a 4 KB boundary.
 */
module burst_addr_gen (
    input  axi_rd_pkg::addr_t  start_addr,
    input  axi_rd_pkg::addr_t  cur_addr,
    input  axi_rd_pkg::size_t  size,
    input  axi_rd_pkg::len_t   len,
    input  axi_rd_pkg::burst_e burst,
    output axi_rd_pkg::addr_t  next_addr
);
    import axi_rd_pkg::*;

    addr_t beat_bytes;
    addr_t span;
    addr_t aligned;
    addr_t incr_addr;
    addr_t boundary;
    logic  wrap_hit;

    assign beat_bytes = addr_t'(1) << size;
    assign span       = beat_bytes * (addr_t'(len) + addr_t'(1));

    // Step from the size-aligned current address
    assign aligned   = cur_addr & ~(beat_bytes - addr_t'(1));
    assign incr_addr = aligned + beat_bytes;

    // Wrap window is aligned to the whole burst span
    assign boundary = start_addr & ~(span - addr_t'(1));
    assign wrap_hit = (incr_addr == boundary + span);

    always_comb begin
        case (burst)
            FIXED:   next_addr = start_addr;
            INCR:    next_addr = incr_addr;
            WRAP:    next_addr = wrap_hit ? boundary : incr_addr;
            default: next_addr = incr_addr;
        endcase
    end

endmodule

//--- ost_entry.sv
`timescale 1ns/1ps
/*
 * One outstanding read burst with a slow modelled fetch and an 8-beat buffer.
 * Each beat is fetched FETCH_BASE_DLY minus ID cycles after the previous one.
 * alloc is only legal while busy is low, and arlen above 7 is not supported.
 */
module ost_entry (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               alloc,
    input  axi_rd_pkg::id_t    ar_id,
    input  axi_rd_pkg::addr_t  ar_addr,
    input  axi_rd_pkg::len_t   ar_len,
    input  axi_rd_pkg::size_t  ar_size,
    input  axi_rd_pkg::burst_e ar_burst,
    input  logic               beat_sent,
    output logic               busy,
    output logic               beat_ready,
    output axi_rd_pkg::id_t    beat_id,
    output axi_rd_pkg::data_t  beat_data,
    output axi_rd_pkg::resp_t  beat_resp,
    output logic               beat_last
);
    import axi_rd_pkg::*;

    // Stored request
    id_t    id_q;
    addr_t  start_q;
    len_t   len_q;
    size_t  size_q;
    burst_e burst_q;

    // Fetch side
    fetch_cnt_t fetch_cnt;
    fetch_cnt_t fetch_dly;
    beat_idx_t  fetch_idx;
    addr_t      cur_addr;
    addr_t      next_addr;
    logic       fetch;
    logic       fetch_last;
    resp_t      last_resp;

    // Beat buffer and send side
    data_t                    beat_buf [MAX_BURST_LEN];
    logic [MAX_BURST_LEN-1:0] beat_vld;
    logic [MAX_BURST_LEN-1:0] beat_vld_d;
    beat_idx_t                send_idx;
    beat_idx_t                send_idx_d;
    logic                     busy_d;

    burst_addr_gen u_addr_gen (
        .start_addr (start_q),
        .cur_addr   (cur_addr),
        .size       (size_q),
        .len        (len_q),
        .burst      (burst_q),
        .next_addr  (next_addr)
    );

    // ------------------------------
    // Request payload and beat data
    // ------------------------------
    always_ff @(posedge clk) begin
        if (alloc) begin
            id_q     <= ar_id;
            start_q  <= ar_addr;
            len_q    <= ar_len;
            size_q   <= ar_size;
            burst_q  <= ar_burst;
            cur_addr <= ar_addr;
            for (int i = 0; i < MAX_BURST_LEN; i++) begin
                beat_buf[i] <= '0;
            end
        end else if (fetch) begin
            cur_addr            <= next_addr;
            beat_buf[fetch_idx] <= data_t'({id_q, cur_addr});
            if (fetch_last) begin
                // Error injection on the all-ones ID
                last_resp <= (id_q == '1) ? RESP_SLVERR : RESP_OKAY;
            end
        end
    end

    // ------------------------------
    // Fetch timer
    // ------------------------------
    assign fetch_dly  = fetch_cnt_t'(FETCH_BASE_DLY - int'(id_q));
    assign fetch      = busy & (fetch_cnt == fetch_dly);
    assign fetch_last = fetch & (fetch_idx == beat_idx_t'(len_q));

    // Zero count means no fetch pending
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_cnt <= '0;
            fetch_idx <= '0;
        end else if (alloc) begin
            fetch_cnt <= fetch_cnt_t'(1);
            fetch_idx <= '0;
        end else if (fetch) begin
            fetch_cnt <= fetch_last ? '0 : fetch_cnt_t'(1);
            fetch_idx <= fetch_idx + beat_idx_t'(1);
        end else if (fetch_cnt != '0) begin
            fetch_cnt <= fetch_cnt + fetch_cnt_t'(1);
        end
    end

    // ------------------------------
    // Send progress
    // ------------------------------
    always_comb begin
        beat_vld_d = beat_vld;
        send_idx_d = send_idx;
        busy_d     = busy;
        if (alloc) begin
            beat_vld_d = '0;
            send_idx_d = '0;
            busy_d     = 1'b1;
        end else begin
            if (fetch) begin
                beat_vld_d[fetch_idx] = 1'b1;
            end
            if (beat_sent) begin
                send_idx_d = send_idx + beat_idx_t'(1);
                busy_d     = ~beat_last;
            end
        end
    end

    // Ready is looked up on next state so it comes straight from a flop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            send_idx   <= '0;
            beat_vld   <= '0;
            beat_ready <= 1'b0;
        end else begin
            busy       <= busy_d;
            send_idx   <= send_idx_d;
            beat_vld   <= beat_vld_d;
            beat_ready <= busy_d & beat_vld_d[send_idx_d];
        end
    end

    assign beat_id   = id_q;
    assign beat_data = beat_buf[send_idx];
    assign beat_last = (send_idx == beat_idx_t'(len_q));
    assign beat_resp = beat_last ? last_resp : RESP_OKAY;

endmodule

//--- ost_table.sv
`timescale 1ns/1ps
/*
 * Table of outstanding read bursts with round-robin free-slot allocation.
 * arready is combinational and low only while every entry is busy.
 * OST_DEPTH must be a power of two, at least 2.
 */
module ost_table #(
    parameter int OST_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   arvalid,
    input  axi_rd_pkg::id_t        arid,
    input  axi_rd_pkg::addr_t      araddr,
    input  axi_rd_pkg::len_t       arlen,
    input  axi_rd_pkg::size_t      arsize,
    input  axi_rd_pkg::burst_e     arburst,
    output logic                   arready,
    input  logic [OST_DEPTH-1:0]   beat_sent,
    output logic [OST_DEPTH-1:0]   beat_ready,
    output axi_rd_pkg::id_t        beat_id   [OST_DEPTH],
    output axi_rd_pkg::data_t      beat_data [OST_DEPTH],
    output axi_rd_pkg::resp_t      beat_resp [OST_DEPTH],
    output logic [OST_DEPTH-1:0]   beat_last
);
    import axi_rd_pkg::*;

    localparam int IDX_W = $clog2(OST_DEPTH);

    logic [OST_DEPTH-1:0] busy;
    logic [OST_DEPTH-1:0] free_vec;
    logic [OST_DEPTH-1:0] alloc;
    logic [IDX_W-1:0]     free_ptr;
    logic                 any_free;
    logic                 full;
    logic                 ar_hs;

    // ------------------------------
    // Slot allocation
    // ------------------------------
    assign free_vec = ~busy;
    assign full     = ~any_free;
    assign arready  = ~full;
    assign ar_hs    = arvalid & arready;

    rr_arbiter #(
        .DEPTH (OST_DEPTH)
    ) u_free_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (free_vec),
        .grant_en (ar_hs),
        .ptr      (free_ptr),
        .any_req  (any_free)
    );

    always_comb begin
        alloc = '0;
        if (ar_hs) begin
            alloc[free_ptr] = 1'b1;
        end
    end

    // ------------------------------
    // Entries
    // ------------------------------
    for (genvar g = 0; g < OST_DEPTH; g++) begin : g_entry
        ost_entry u_entry (
            .clk        (clk),
            .rst_n      (rst_n),
            .alloc      (alloc[g]),
            .ar_id      (arid),
            .ar_addr    (araddr),
            .ar_len     (arlen),
            .ar_size    (arsize),
            .ar_burst   (arburst),
            .beat_sent  (beat_sent[g]),
            .busy       (busy[g]),
            .beat_ready (beat_ready[g]),
            .beat_id    (beat_id[g]),
            .beat_data  (beat_data[g]),
            .beat_resp  (beat_resp[g]),
            .beat_last  (beat_last[g])
        );
    end

endmodule

//--- r_channel_ctrl.sv
`timescale 1ns/1ps
/*
 * R channel driver that picks a ready entry and stays on it until rlast.
 * Bursts complete out of order but their beats are never interleaved.
 * rvalid may drop between beats of a locked burst while a fetch is pending.
 */
module r_channel_ctrl #(
    parameter int OST_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [OST_DEPTH-1:0] beat_ready,
    input  axi_rd_pkg::id_t      beat_id   [OST_DEPTH],
    input  axi_rd_pkg::data_t    beat_data [OST_DEPTH],
    input  axi_rd_pkg::resp_t    beat_resp [OST_DEPTH],
    input  logic [OST_DEPTH-1:0] beat_last,
    output logic [OST_DEPTH-1:0] beat_sent,
    output logic                 rvalid,
    input  logic                 rready,
    output axi_rd_pkg::id_t      rid,
    output axi_rd_pkg::data_t    rdata,
    output axi_rd_pkg::resp_t    rresp,
    output logic                 rlast
);
    import axi_rd_pkg::*;

    localparam int IDX_W = $clog2(OST_DEPTH);

    logic             lock_q;
    logic [IDX_W-1:0] lock_idx_q;
    logic [IDX_W-1:0] arb_ptr;
    logic [IDX_W-1:0] sel;
    logic             arb_any;
    logic             grant;
    logic             r_hs;

    rr_arbiter #(
        .DEPTH (OST_DEPTH)
    ) u_r_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (beat_ready),
        .grant_en (grant),
        .ptr      (arb_ptr),
        .any_req  (arb_any)
    );

    // Idle takes the arbiter choice in the same cycle
    assign grant = ~lock_q & arb_any;
    assign sel   = lock_q ? lock_idx_q : arb_ptr;

    assign rvalid = beat_ready[sel];
    assign rid    = beat_id[sel];
    assign rdata  = beat_data[sel];
    assign rresp  = beat_resp[sel];
    assign rlast  = beat_last[sel];
    assign r_hs   = rvalid & rready;

    always_comb begin
        beat_sent = '0;
        if (r_hs) begin
            beat_sent[sel] = 1'b1;
        end
    end

    // Single-beat bursts never take the lock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else if (r_hs && rlast) begin
            lock_q <= 1'b0;
        end else if (grant) begin
            lock_q     <= 1'b1;
            lock_idx_q <= arb_ptr;
        end
    end

endmodule

//--- rr_arbiter.sv
`timescale 1ns/1ps
/*
 * Round-robin pointer over a request vector.
 * DEPTH must be a power of two and at least 2, so the index wraps naturally.
 * ptr only names a requester when any_req is high.
 */
module rr_arbiter #(
    parameter int DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [DEPTH-1:0]         req,
    input  logic                     grant_en,
    output logic [$clog2(DEPTH)-1:0] ptr,
    output logic                     any_req
);

    localparam int IDX_W = $clog2(DEPTH);

    // Highest priority index
    logic [IDX_W-1:0] base_q;
    logic [IDX_W-1:0] cand;

    // Scan from the far end back so the nearest requester wins
    always_comb begin
        ptr     = base_q;
        any_req = 1'b0;
        cand    = base_q;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            cand = base_q + IDX_W'(i);
            if (req[cand]) begin
                ptr     = cand;
                any_req = 1'b1;
            end
        end
    end

    // Priority moves just past the granted index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_q <= '0;
        end else if (grant_en) begin
            base_q <= ptr + IDX_W'(1);
        end
    end

endmodule

//--- tb_axi_rd_slave.sv
`timescale 1ns/1ps
/*
 * Directed testbench for the AXI read slave, with a beat model keyed by ID.
 * Each ID has at most one open request at a time, and bursts are at most 8 beats.
 * Outputs are sampled 1 ns before the rising edge and inputs change on the falling edge.
 */
module tb_axi_rd_slave;
    import axi_rd_pkg::*;

    localparam int OST_DEPTH  = 4;
    localparam int SAMPLE_DLY = 4;
    // Worst burst is 8 beats of 20 cycles, six tests, generous margin
    localparam int WATCHDOG_NS = 20000;

    logic   clk;
    logic   rst_n;
    logic   arvalid;
    logic   arready;
    id_t    arid;
    addr_t  araddr;
    len_t   arlen;
    size_t  arsize;
    burst_e arburst;
    logic   rvalid;
    logic   rready;
    id_t    rid;
    data_t  rdata;
    resp_t  rresp;
    logic   rlast;

    // Beat model, one slot per ID
    logic [31:0] exp_data [16][8];
    int          exp_len  [16];
    int          beat_cnt [16];
    bit          pend     [16];
    int          issued_count;
    int          done_count;
    int          errors;
    integer      seed;

    // Burst contiguity and stall tracking
    bit    in_burst;
    id_t   cur_id;
    bit    stalled;
    data_t held_data;
    id_t   held_id;
    resp_t held_resp;
    logic  held_last;

    axi_rd_slave #(
        .OST_DEPTH (OST_DEPTH)
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast)
    );

    always #5 clk = ~clk;

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // Beat address from the AXI burst rules
    function automatic addr_t beat_addr(input addr_t start, input int size, input int len,
                                        input burst_e burst, input int n);
        int bytes;
        int aligned;
        int span;
        int lower;
        bytes   = 1 << size;
        aligned = (int'(start) / bytes) * bytes;
        span    = bytes * (len + 1);
        lower   = (int'(start) / span) * span;
        if (burst == FIXED || n == 0) begin
            return start;
        end
        if (burst == WRAP) begin
            return addr_t'(lower + (aligned - lower + n * bytes) % span);
        end
        return addr_t'(aligned + n * bytes);
    endfunction

    // Leaves arvalid high so the next request can follow without a gap
    task automatic send_ar(input id_t id, input addr_t addr, input int len, input int size,
                           input burst_e burst);
        logic got;
        for (int n = 0; n <= len; n++) begin
            exp_data[id][n] = {12'h000, id, beat_addr(addr, size, len, burst, n)};
        end
        exp_len[id]  = len;
        beat_cnt[id] = 0;
        pend[id]     = 1'b1;
        issued_count++;
        @(negedge clk);
        arvalid = 1'b1;
        arid    = id;
        araddr  = addr;
        arlen   = len_t'(len);
        arsize  = size_t'(size);
        arburst = burst;
        do begin
            #SAMPLE_DLY;
            got = arready;
            @(posedge clk);
        end while (!got);
    endtask

    task automatic ar_idle();
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    task automatic wait_all_done(input int max_cycles);
        int cycles;
        cycles = 0;
        while (done_count != issued_count && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        assert (done_count == issued_count) else begin
            $display("Requests still open after %0d cycles of waiting", max_cycles);
            errors++;
        end
    endtask

    task automatic collect_beat();
        int n;
        n = beat_cnt[rid];
        if (in_burst) begin
            check_eq("rid", rid, cur_id);
        end
        assert (pend[rid]) else begin
            $display("A beat came back for ID %0d that has no open request", rid);
            errors++;
        end
        if (pend[rid]) begin
            check_eq("rdata", rdata, exp_data[rid][n]);
            check_eq("rresp", rresp, (n == exp_len[rid] && rid == 4'hf) ? RESP_SLVERR : RESP_OKAY);
            check_eq("rlast", rlast, n == exp_len[rid]);
            beat_cnt[rid] = n + 1;
            in_burst      = !rlast;
            cur_id        = rid;
            if (rlast) begin
                pend[rid] = 1'b0;
                done_count++;
            end
        end
    endtask

    // Every R handshake goes through the model
    always begin
        @(negedge clk);
        #SAMPLE_DLY;
        if (stalled) begin
            check_eq("rvalid", rvalid, 1'b1);
            check_eq("rdata", rdata, held_data);
            check_eq("rid", rid, held_id);
            check_eq("rresp", rresp, held_resp);
            check_eq("rlast", rlast, held_last);
        end
        if (rst_n && rvalid && rready) begin
            collect_beat();
        end
        stalled   = rst_n && rvalid && !rready;
        held_data = rdata;
        held_id   = rid;
        held_resp = rresp;
        held_last = rlast;
    end

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic reset_defaults();
        @(negedge clk);
        #SAMPLE_DLY;
        check_eq("rvalid", rvalid, 1'b0);
        check_eq("arready", arready, 1'b1);
    endtask

    task automatic single_incr_burst();
        send_ar(4'd3, 16'h1002, 3, 2, INCR);
        ar_idle();
        wait_all_done(200);
    endtask

    task automatic wrap_and_fixed_bursts();
        send_ar(4'd5, 16'h2008, 3, 2, WRAP);
        send_ar(4'd6, 16'h3010, 2, 2, FIXED);
        ar_idle();
        wait_all_done(300);
    endtask

    task automatic slverr_on_last_beat();
        send_ar(4'd15, 16'h4000, 2, 2, INCR);
        ar_idle();
        wait_all_done(100);
    endtask

    task automatic multi_id_bursts();
        send_ar(4'd1, 16'h0100, 7, 2, INCR);
        send_ar(4'd7, 16'h0204, 0, 2, INCR);
        send_ar(4'd2, 16'h0304, 5, 1, INCR);
        send_ar(4'd9, 16'h0418, 3, 3, WRAP);
        ar_idle();
        wait_all_done(400);
    endtask

    task automatic backpressure_drain();
        int rnd;
        int cycles;
        @(negedge clk);
        rready = 1'b0;
        for (int i = 0; i < OST_DEPTH; i++) begin
            send_ar(id_t'(4 + 2 * i), addr_t'(16'h5000 + 16'h100 * i), (3 * i + 1) % 8, 2,
                    burst_e'(i % 3));
        end
        ar_idle();
        #SAMPLE_DLY;
        check_eq("arready", arready, 1'b0);
        cycles = 0;
        while (done_count != issued_count && cycles < 2000) begin
            @(negedge clk);
            rnd    = $random(seed);
            rready = rnd[0];
            cycles++;
        end
        @(negedge clk);
        rready = 1'b1;
        wait_all_done(10);
        @(negedge clk);
        #SAMPLE_DLY;
        check_eq("arready", arready, 1'b1);
    endtask

    task automatic finish_run();
        $display("Summary: %0d errors, %0d of %0d requests done", errors, done_count,
                 issued_count);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        errors++;
        finish_run();
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        arvalid      = 1'b0;
        arid         = '0;
        araddr       = '0;
        arlen        = '0;
        arsize       = '0;
        arburst      = INCR;
        rready       = 1'b0;
        seed         = 32'hb6fa_fd1e;
        issued_count = 0;
        done_count   = 0;
        errors       = 0;
        in_burst     = 1'b0;
        stalled      = 1'b0;
        for (int i = 0; i < 16; i++) begin
            pend[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n  = 1'b1;
        rready = 1'b1;
        reset_defaults();
        single_incr_burst();
        wrap_and_fixed_bursts();
        slverr_on_last_beat();
        multi_id_bursts();
        backpressure_drain();
        finish_run();
    end

endmodule
